//--- files.f
design/io_pkg.sv
design/io_decode.sv
design/gpio_port.sv
design/tick_timer.sv
design/led_pwm.sv
design/button_capture.sv
design/io_top.sv
tests/tb_clock.sv
tests/tb_io_top.sv

//--- tests/tb_io_top.sv
`timescale 1ns/1ps

module tb_io_top;

  localparam int clk_period = 4;
  // Rough cycle budget of each test
  localparam int len_reset   = 40;
  localparam int len_port    = 80;
  localparam int len_timer   = 60;
  localparam int len_leds    = 220;
  localparam int len_buttons = 40;
  localparam int len_comb    = 10;
  localparam int len_margin  = 100;
  localparam int run_cycles  = len_reset + len_port + len_timer + len_leds
                               + len_buttons + len_comb + len_margin;

  // Addresses with the bit operation in the low two bits
  localparam logic [15:0] a_in      = 16'h0100;
  localparam logic [15:0] a_out     = 16'h0200;
  localparam logic [15:0] a_dir     = 16'h0400;
  localparam logic [15:0] a_led     = 16'h08B0;
  localparam logic [15:0] a_sdm_r   = 16'h08C0;
  localparam logic [15:0] a_sdm_g   = 16'h08D0;
  localparam logic [15:0] a_sdm_b   = 16'h08E0;
  localparam logic [15:0] a_buttons = 16'h08F0;
  localparam logic [15:0] a_ticks   = 16'h4000;
  localparam logic [15:0] a_cycles  = 16'h8000;

  logic            clk;
  logic            arst_n;
  logic            io_rd;
  logic            io_wr;
  io_pkg::word_t   io_addr;
  io_pkg::word_t   io_dout;
  io_pkg::word_t   io_din;
  io_pkg::spi_wr_t spi_wr;
  logic [7:0]      pin_in;
  logic [7:0]      pin_out;
  logic [7:0]      pin_oe;
  logic [2:0]      led;
  logic            irq;

  integer seed = 40;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     errs_at_start = 0;

  // Reference model state
  logic [7:0]  out_m = '0;
  logic [7:0]  dir_m = '0;
  logic [10:0] btn_m = '0;

  tb_clock u_clk (.clk(clk));

  io_top u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .io_rd   (io_rd),
    .io_wr   (io_wr),
    .io_addr (io_addr),
    .io_dout (io_dout),
    .io_din  (io_din),
    .spi_wr  (spi_wr),
    .pin_in  (pin_in),
    .pin_out (pin_out),
    .pin_oe  (pin_oe),
    .led     (led),
    .irq     (irq)
  );

  // Outputs idle while reset is held
  assert property (@(posedge clk) !arst_n |-> (irq == 1'b0 && led == '0 && pin_oe == '0))
    else begin
      $display("FAIL %0t: outputs active during reset", $time);
      errors++;
    end

  // Interrupt is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!arst_n) irq |=> !irq)
    else begin
      $display("FAIL %0t: irq high for more than one cycle", $time);
      errors++;
    end

  task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Model of write, clear, set and toggle on one register
  function automatic logic [7:0] apply_bit_op(input logic [7:0] cur, input logic [7:0] d,
                                              input logic [1:0] op);
    logic [7:0] res;
    res = d;                    // op 0 plain write
    if (op == 2'd1) res = cur & ~d;
    if (op == 2'd2) res = cur | d;
    if (op == 2'd3) res = cur ^ d;
    return res;
  endfunction

  // Returns on the write edge with io_wr already dropped
  task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
    @(posedge clk);
    io_wr   <= 1'b1;
    io_addr <= addr;
    io_dout <= data;
    @(posedge clk);
    io_wr   <= 1'b0;
    io_addr <= '0;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
    @(posedge clk);
    io_rd   <= 1'b1;
    io_addr <= addr;
    @(negedge clk);
    data = io_din;              // Mid-cycle once the combinational path settles
    @(posedge clk);
    io_rd   <= 1'b0;
    io_addr <= '0;
  endtask

  // Command byte then four payload bytes with the first at the top
  task automatic spi_frame(input logic [7:0] cmd_byte, input logic [31:0] payload);
    @(posedge clk);
    spi_wr.data <= cmd_byte;
    spi_wr.cmd  <= 1'b1;
    spi_wr.stb  <= 1'b1;
    for (int i = 3; i >= 0; i--) begin
      @(posedge clk);
      spi_wr.data <= payload[i*8 +: 8];
      spi_wr.cmd  <= 1'b0;
    end
    @(posedge clk);
    spi_wr.stb       <= 1'b0;
    spi_wr.frame_end <= 1'b1;
    @(posedge clk);
    spi_wr.frame_end <= 1'b0;
    if (cmd_byte == 8'hF4) btn_m = payload[26:16]; // Only button frames latch
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %-8s done, %0d errors", name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  initial begin
    logic [15:0] rd;
    logic [15:0] rd2;
    logic [15:0] d;
    logic [31:0] payload;
    time         t1;
    time         t2;
    int          red_hi;
    int          gap;

    arst_n  = 1'b0;
    io_rd   = 1'b0;
    io_wr   = 1'b0;
    io_addr = '0;
    io_dout = '0;
    spi_wr  = '0;
    pin_in  = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // Reset state
    @(negedge clk);
    check_eq("pin_oe", 16'(pin_oe), 16'h0);
    check_eq("led", 16'(led), 16'h0);
    check_eq("irq", 16'(irq), 16'h0);
    bus_read(a_out, rd);
    check_eq("OUT", rd, 16'h0);
    bus_read(a_dir, rd);
    check_eq("DIR", rd, 16'h0);
    bus_read(a_led, rd);
    check_eq("LED", rd, 16'h0);
    bus_read(a_sdm_r, rd);
    check_eq("SDM R", rd, 16'h0);
    bus_read(a_sdm_g, rd);
    check_eq("SDM G", rd, 16'h0);
    bus_read(a_sdm_b, rd);
    check_eq("SDM B", rd, 16'h0);
    bus_read(a_buttons, rd);
    check_eq("BUTTONS", rd, 16'h0);
    end_test("reset");

    // Port registers through every bit operation
    for (int op = 0; op < 4; op++) begin
      d = $random(seed);
      bus_write(a_out | 16'(op), d);
      out_m = apply_bit_op(out_m, d[7:0], 2'(op));
      @(negedge clk);
      check_eq("pin_out", 16'(pin_out), 16'(out_m));
      bus_read(a_out, rd);
      check_eq("OUT", rd, 16'(out_m));
      d = $random(seed);
      bus_write(a_dir | 16'(op), d);
      dir_m = apply_bit_op(dir_m, d[7:0], 2'(op));
      @(negedge clk);
      check_eq("pin_oe", 16'(pin_oe), 16'(dir_m));
      bus_read(a_dir, rd);
      check_eq("DIR", rd, 16'(dir_m));
    end
    @(posedge clk);
    pin_in <= 8'($random(seed));
    repeat (3) @(posedge clk);   // Input register plus margin
    bus_read(a_in, rd);
    check_eq("IN", rd, 16'(pin_in));
    end_test("port");

    // Tick overflow interrupt and cycle counter
    bus_write(a_ticks, 16'hFFF0);
    for (int k = 1; k <= 18; k++) begin
      @(negedge clk);
      check_eq($sformatf("irq %0d cycles after load", k), 16'(irq), 16'(k == 17));
    end
    bus_read(a_cycles, rd);
    t1  = $time;
    gap = 3 + ($random(seed) & 7);
    repeat (gap) @(posedge clk);
    bus_read(a_cycles, rd2);
    t2  = $time;
    check_eq("cycle delta", rd2 - rd, 16'((t2 - t1) / clk_period));
    end_test("timer");

    // Static green and blue with red from the modulator
    bus_write(a_led, 16'h0006);
    bus_read(a_led, rd);
    check_eq("LED", rd, 16'h0006);
    repeat (2) @(negedge clk);
    for (int k = 0; k < 32; k++) begin
      @(negedge clk);
      check_eq("led lines", 16'(led), 16'h0006);
    end
    bus_write(a_sdm_r, 16'h4000);
    bus_read(a_sdm_r, rd);
    check_eq("SDM R", rd, 16'h4000);
    red_hi = 0;
    for (int k = 0; k < 64; k++) begin
      @(negedge clk);
      red_hi += led[0];
      check_eq("static lines", 16'(led[2:1]), 16'h0003);
    end
    check_eq("red high count", 16'(red_hi), 16'd16); // Quarter duty
    end_test("leds");

    // Button frames with matching and foreign command
    payload = $random(seed);
    spi_frame(8'hF4, payload);
    bus_read(a_buttons, rd);
    check_eq("BUTTONS", rd, 16'(btn_m));
    payload = $random(seed);
    spi_frame(8'hA5, payload);
    bus_read(a_buttons, rd);
    check_eq("BUTTONS after other cmd", rd, 16'(btn_m));
    end_test("buttons");

    // OUT and DIR selected together
    bus_read(a_out | a_dir, rd);
    check_eq("OUT|DIR", rd, 16'(out_m | dir_m));
    end_test("combine");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(run_cycles * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", run_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

endmodule

//--- design/io_top.sv
`timescale 1ns/1ps

module io_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      io_rd,   // Reads have no side effects
  input  logic                      io_wr,
  input  io_pkg::word_t             io_addr,
  input  io_pkg::word_t             io_dout,
  output io_pkg::word_t             io_din,
  input  io_pkg::spi_wr_t           spi_wr,
  input  logic [io_pkg::pin_w-1:0]  pin_in,
  output logic [io_pkg::pin_w-1:0]  pin_out,
  output logic [io_pkg::pin_w-1:0]  pin_oe,
  output logic [io_pkg::led_w-1:0]  led,
  output logic                      irq
);

  io_pkg::io_wr_t       wr_en;
  io_pkg::bit_op_t      op;
  wire io_pkg::io_rd_t  rd_vals;  // Fields driven by each peripheral

  io_decode u_decode (
    .io_wr   (io_wr),
    .io_addr (io_addr),
    .rd_vals (rd_vals),
    .wr_en   (wr_en),
    .op      (op),
    .io_din  (io_din)
  );

  gpio_port u_gpio (
    .clk          (clk),
    .arst_n       (arst_n),
    .wr_en        (wr_en),
    .op           (op),
    .wdata        (io_dout),
    .pin_in       (pin_in),
    .pin_out      (pin_out),
    .pin_oe       (pin_oe),
    .rd_vals_gpio ({rd_vals.pin_in, rd_vals.pin_out, rd_vals.pin_dir})
  );

  tick_timer u_timer (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_en  (wr_en),
    .wdata  (io_dout),
    .irq    (irq),
    .ticks  (rd_vals.ticks),
    .cycles (rd_vals.cycles)
  );

  // Static bits and sigma-delta per colour
  led_pwm u_led (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_en  (wr_en),
    .op     (op),
    .wdata  (io_dout),
    .led    (led),
    .leds   (rd_vals.leds),
    .sdm_r  (rd_vals.sdm_r),
    .sdm_g  (rd_vals.sdm_g),
    .sdm_b  (rd_vals.sdm_b)
  );

  // Fed straight from the SPI protocol layer
  button_capture u_buttons (
    .clk     (clk),
    .arst_n  (arst_n),
    .spi_wr  (spi_wr),
    .buttons (rd_vals.buttons)
  );

endmodule

//--- design/button_capture.sv
`timescale 1ns/1ps

module button_capture (
  input  logic                      clk,
  input  logic                      arst_n,
  input  io_pkg::spi_wr_t           spi_wr,
  output logic [io_pkg::btn_w-1:0]  buttons
);

  logic [io_pkg::byte_w-1:0]  cmd_q;    // Last command byte
  logic [io_pkg::shift_w-1:0] shift_q;  // Newest byte at the bottom

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_q   <= '0;
      shift_q <= '0;
      buttons <= '0;
    end else begin
      if (spi_wr.stb && spi_wr.cmd) begin
        cmd_q <= spi_wr.data;
      end
      if (spi_wr.stb) begin
        shift_q <= {shift_q[io_pkg::shift_w-io_pkg::byte_w-1:0], spi_wr.data};
      end
      // Latch only frames carrying button state
      if (spi_wr.frame_end && (cmd_q == io_pkg::btn_cmd)) begin
        buttons <= shift_q[io_pkg::btn_lsb +: io_pkg::btn_w];
      end
    end
  end

endmodule

//--- design/led_pwm.sv
`timescale 1ns/1ps

module led_pwm (
  input  logic                      clk,
  input  logic                      arst_n,
  input  io_pkg::io_wr_t            wr_en,
  input  io_pkg::bit_op_t           op,
  input  io_pkg::word_t             wdata,
  output logic [io_pkg::led_w-1:0]  led,
  output logic [io_pkg::led_w-1:0]  leds,
  output io_pkg::word_t             sdm_r,
  output io_pkg::word_t             sdm_g,
  output io_pkg::word_t             sdm_b
);

  logic [io_pkg::led_w-1:0] leds_q;    // Static on bits
  io_pkg::word_t            leds_next;
  logic [io_pkg::led_w-1:0] sdm_we;    // Per channel setting write
  logic [io_pkg::led_w-1:0] sdm_bit;   // Modulator carries
  io_pkg::word_t            setting [io_pkg::led_w];

  assign leds_next = io_pkg::bit_modify(io_pkg::word_t'(leds_q), wdata, op);
  assign sdm_we    = {wr_en.sdm_b, wr_en.sdm_g, wr_en.sdm_r}; // Index 0 is red

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      leds_q <= '0;
    end else if (wr_en.led) begin
      leds_q <= leds_next[io_pkg::led_w-1:0];
    end
  end

  // One first-order sigma-delta per colour
  for (genvar i = 0; i < io_pkg::led_w; i++) begin : g_sdm
    io_pkg::word_t           phase;
    logic [io_pkg::word_w:0] sum;  // Carry on top

    assign sum        = {1'b0, phase} + {1'b0, setting[i]};
    assign sdm_bit[i] = sum[io_pkg::word_w];

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        setting[i] <= '0;
        phase      <= '0;
      end else if (sdm_we[i]) begin
        setting[i] <= wdata;
        phase      <= '0;  // Restart the accumulator
      end else begin
        phase <= sum[io_pkg::word_w-1:0];
      end
    end
  end

  // Line is static bit or modulator output
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led <= '0;
    end else begin
      led <= leds_q | sdm_bit;
    end
  end

  assign leds  = leds_q;
  assign sdm_r = setting[0];
  assign sdm_g = setting[1];
  assign sdm_b = setting[2];

endmodule

//--- design/tick_timer.sv
`timescale 1ns/1ps

module tick_timer (
  input  logic            clk,
  input  logic            arst_n,
  input  io_pkg::io_wr_t  wr_en,
  input  io_pkg::word_t   wdata,
  output logic            irq,
  output io_pkg::word_t   ticks,
  output io_pkg::word_t   cycles
);

  logic [io_pkg::word_w:0] ticks_inc; // Extra bit holds the carry

  assign ticks_inc = {1'b0, ticks} + 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ticks  <= '0;
      irq    <= 1'b0;
      cycles <= '0;
    end else begin
      if (wr_en.ticks) begin
        ticks <= wdata;  // Bus load wins over counting
      end else begin
        ticks <= ticks_inc[io_pkg::word_w-1:0];
      end
      // One-cycle pulse after FFFF wraps to zero
      irq    <= ticks_inc[io_pkg::word_w] & ~wr_en.ticks;
      cycles <= cycles + 1'b1; // Free running
    end
  end

endmodule

//--- design/gpio_port.sv
`timescale 1ns/1ps

module gpio_port (
  input  logic                         clk,
  input  logic                         arst_n,
  input  io_pkg::io_wr_t               wr_en,
  input  io_pkg::bit_op_t              op,
  input  io_pkg::word_t                wdata,
  input  logic [io_pkg::pin_w-1:0]     pin_in,
  output logic [io_pkg::pin_w-1:0]     pin_out,
  output logic [io_pkg::pin_w-1:0]     pin_oe,
  output logic [3*io_pkg::pin_w-1:0]   rd_vals_gpio  // {in, out, dir}
);

  logic [io_pkg::pin_w-1:0] in_q;   // Sampled pins
  logic [io_pkg::pin_w-1:0] out_q;
  logic [io_pkg::pin_w-1:0] dir_q;  // 1 drives the pin
  io_pkg::word_t            out_next;
  io_pkg::word_t            dir_next;

  // Modified values with upper bits dropped on store
  assign out_next = io_pkg::bit_modify(io_pkg::word_t'(out_q), wdata, op);
  assign dir_next = io_pkg::bit_modify(io_pkg::word_t'(dir_q), wdata, op);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_q  <= '0;
      out_q <= '0;
      dir_q <= '0;  // All pins input after reset
    end else begin
      in_q <= pin_in; // Input register like the pad cells
      if (wr_en.out) begin
        out_q <= out_next[io_pkg::pin_w-1:0];
      end
      if (wr_en.dir) begin
        dir_q <= dir_next[io_pkg::pin_w-1:0];
      end
    end
  end

  assign pin_out      = out_q;
  assign pin_oe       = dir_q;
  assign rd_vals_gpio = {in_q, out_q, dir_q};

endmodule

//--- design/io_decode.sv
`timescale 1ns/1ps

module io_decode (
  input  logic              io_wr,
  input  io_pkg::word_t     io_addr,
  input  io_pkg::io_rd_t    rd_vals,
  output io_pkg::io_wr_t    wr_en,
  output io_pkg::bit_op_t   op,
  output io_pkg::word_t     io_din
);

  logic                     misc;  // Misc region hit
  logic [io_pkg::sel_w-1:0] sel;   // Sub-address within misc region

  assign misc = io_addr[io_pkg::addr_misc_bit];
  assign sel  = io_addr[io_pkg::sel_lsb +: io_pkg::sel_w];

  // Bit operation rides on the two lowest address bits
  assign op = io_pkg::bit_op_t'(io_addr[1:0]);

  // Write enables
  always_comb begin
    wr_en       = '0;
    wr_en.out   = io_wr & io_addr[io_pkg::addr_out_bit];
    wr_en.dir   = io_wr & io_addr[io_pkg::addr_dir_bit];
    wr_en.led   = io_wr & misc & (sel == io_pkg::sel_led);
    wr_en.sdm_r = io_wr & misc & (sel == io_pkg::sel_sdm_r);
    wr_en.sdm_g = io_wr & misc & (sel == io_pkg::sel_sdm_g);
    wr_en.sdm_b = io_wr & misc & (sel == io_pkg::sel_sdm_b);
    wr_en.ticks = io_wr & io_addr[io_pkg::addr_ticks_bit]; // Load tick counter
  end

  // Read mux ORs in every matching source
  always_comb begin
    io_din = '0;
    if (io_addr[io_pkg::addr_in_bit]) begin
      io_din |= io_pkg::word_t'(rd_vals.pin_in);
    end
    if (io_addr[io_pkg::addr_out_bit]) begin
      io_din |= io_pkg::word_t'(rd_vals.pin_out);
    end
    if (io_addr[io_pkg::addr_dir_bit]) begin
      io_din |= io_pkg::word_t'(rd_vals.pin_dir);
    end
    if (misc && (sel == io_pkg::sel_led)) begin
      io_din |= io_pkg::word_t'(rd_vals.leds); // Static LED bits only
    end
    if (misc && (sel == io_pkg::sel_sdm_r)) begin
      io_din |= rd_vals.sdm_r;
    end
    if (misc && (sel == io_pkg::sel_sdm_g)) begin
      io_din |= rd_vals.sdm_g;
    end
    if (misc && (sel == io_pkg::sel_sdm_b)) begin
      io_din |= rd_vals.sdm_b;
    end
    if (misc && (sel == io_pkg::sel_buttons)) begin
      io_din |= io_pkg::word_t'(rd_vals.buttons);
    end
    if (io_addr[io_pkg::addr_ticks_bit]) begin
      io_din |= rd_vals.ticks;
    end
    if (io_addr[io_pkg::addr_cycles_bit]) begin
      io_din |= rd_vals.cycles;
    end
  end

endmodule

//--- design/io_pkg.sv
package io_pkg;

  // Bus and peripheral widths
  localparam int word_w  = 16;
  localparam int pin_w   = 8;   // GPIO port pins
  localparam int led_w   = 3;   // RGB lines
  localparam int btn_w   = 11;
  localparam int btn_lsb = 16;  // First button bit in shifted word
  localparam int byte_w  = 8;   // SPI byte
  localparam int shift_w = 32;  // Payload shift register

  // One-hot region bits in io_addr
  localparam int addr_in_bit     = 8;
  localparam int addr_out_bit    = 9;
  localparam int addr_dir_bit    = 10;
  localparam int addr_misc_bit   = 11;
  localparam int addr_ticks_bit  = 14;
  localparam int addr_cycles_bit = 15;

  // Selector field inside the misc region
  localparam int sel_lsb = 4;
  localparam int sel_w   = 4;

  localparam logic [sel_w-1:0] sel_led     = 4'd11;
  localparam logic [sel_w-1:0] sel_sdm_r   = 4'd12;
  localparam logic [sel_w-1:0] sel_sdm_g   = 4'd13;
  localparam logic [sel_w-1:0] sel_sdm_b   = 4'd14;
  localparam logic [sel_w-1:0] sel_buttons = 4'd15;

  localparam logic [byte_w-1:0] btn_cmd = 8'hF4; // Button frame command

  typedef logic [word_w-1:0] word_t;

  // Low two address bits pick the read-modify-write flavour
  typedef enum logic [1:0] {
    op_write  = 2'd0,
    op_clear  = 2'd1,
    op_set    = 2'd2,
    op_toggle = 2'd3
  } bit_op_t;

  // Write enables already qualified by io_wr
  typedef struct packed {
    logic out;
    logic dir;
    logic led;
    logic sdm_r;
    logic sdm_g;
    logic sdm_b;
    logic ticks;
  } io_wr_t;

  // Write side of the SPI protocol layer
  typedef struct packed {
    logic [byte_w-1:0] data;
    logic              cmd;       // Byte is the command byte
    logic              stb;       // Byte valid
    logic              frame_end; // Chip select released
  } spi_wr_t;

  // Everything the decoder can read back
  typedef struct packed {
    logic [pin_w-1:0] pin_in;
    logic [pin_w-1:0] pin_out;
    logic [pin_w-1:0] pin_dir;
    logic [led_w-1:0] leds;
    word_t            sdm_r;
    word_t            sdm_g;
    word_t            sdm_b;
    word_t            ticks;
    word_t            cycles;
    logic [btn_w-1:0] buttons;
  } io_rd_t;

  // Write, clear, set or toggle bits of a register
  function automatic word_t bit_modify(word_t old_val, word_t data, bit_op_t op);
    case (op)
      op_write:  return data;
      op_clear:  return old_val & ~data;
      op_set:    return old_val | data;
      op_toggle: return old_val ^ data;
      default:   return data;
    endcase
  endfunction

endpackage
